// ==== rtl/mips_isa_pkg.sv ====
package mips_isa_pkg;

	//////////////////////////////////////////////////
	// machine word and field types
	//////////////////////////////////////////////////

	// data word and byte address
	typedef logic [31:0] word_t;
	// register number
	typedef logic [4:0]  reg_addr_t;
	// raw instruction
	typedef logic [31:0] instr_t;
	// major opcode, bits 31..26
	typedef logic [5:0]  opcode_t;
	// function field of special ops, bits 5..0
	typedef logic [5:0]  funct_t;

	//////////////////////////////////////////////////
	// encodings of the supported subset
	//////////////////////////////////////////////////

	localparam opcode_t op_special = 6'b000000;
	localparam opcode_t op_ori     = 6'b001101;
	localparam opcode_t op_lui     = 6'b001111;
	localparam opcode_t op_lw      = 6'b100011;
	localparam opcode_t op_sw      = 6'b101011;
	localparam opcode_t op_beq     = 6'b000100;
	localparam opcode_t op_jal     = 6'b000011;

	// funct values under op_special
	localparam funct_t fn_add = 6'b100000;
	localparam funct_t fn_sub = 6'b100010;
	localparam funct_t fn_jr  = 6'b001000;

	// first fetch address
	localparam word_t     reset_pc = 32'h0000_0000;
	// jal link target
	localparam reg_addr_t link_reg = 5'd31;

endpackage

// ==== rtl/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

	//////////////////////////////////////////////////
	// decode stage selects
	//////////////////////////////////////////////////

	// next pc source
	typedef enum logic [1:0] {
		pc_plus4,
		branch_imm16,
		jump_imm26,
		jump_reg
	} jump_sel_e;

	// execute stage operation
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_or,
		alu_lui
	} alu_op_e;

	// alu b operand
	typedef enum logic [1:0] {
		src_rt,
		src_sign_ext,
		src_zero_ext
	} src_b_e;

	// write-back value
	typedef enum logic [1:0] {
		wd_alu,
		wd_mem,
		wd_link
	} wdata_sel_e;

	//////////////////////////////////////////////////
	// hazard bookkeeping
	//////////////////////////////////////////////////

	// operand bypass source
	typedef enum logic [1:0] {
		fwd_none,
		fwd_from_e,
		fwd_from_m,
		fwd_from_w
	} fwd_sel_e;

	// stages until an operand is needed or a result exists
	typedef logic [1:0] stage_time_t;
	// operand never read
	localparam stage_time_t tuse_never = 2'd3;

endpackage

// ==== rtl/mem_bus_if.sv ====
`timescale 1ns/1ns

interface mem_bus_if #(
	parameter int dmem_addr_bits = 8
);
	import mips_isa_pkg::*;

	word_t addr;
	word_t wdata;
	logic  we;
	word_t rdata;
	// word index inside the data RAM
	logic [dmem_addr_bits-1:0] word_idx;

	// byte address, low two bits dropped
	assign word_idx = addr[dmem_addr_bits+1:2];

	modport master (output addr, output wdata, output we, input rdata);
	modport slave (input word_idx, input wdata, input we, output rdata);
endinterface

// ==== rtl/insn_decoder.sv ====
`timescale 1ns/1ns

module insn_decoder (
	input  mips_isa_pkg::instr_t       instr,
	output mips_isa_pkg::reg_addr_t    rs,
	output mips_isa_pkg::reg_addr_t    rt,
	output mips_isa_pkg::reg_addr_t    rd,
	output logic [15:0]                imm16,
	output logic [25:0]                imm26,
	output pipe_ctrl_pkg::jump_sel_e   jump_sel,
	output pipe_ctrl_pkg::alu_op_e     alu_op,
	output pipe_ctrl_pkg::src_b_e      src_b,
	output pipe_ctrl_pkg::wdata_sel_e  wdata_sel,
	output pipe_ctrl_pkg::stage_time_t tuse_rs,
	output pipe_ctrl_pkg::stage_time_t tuse_rt,
	output pipe_ctrl_pkg::stage_time_t tnew_e,
	output pipe_ctrl_pkg::stage_time_t tnew_m,
	output mips_isa_pkg::reg_addr_t    dest_reg,
	output logic                       reg_we,
	output logic                       mem_we,
	output logic                       is_load
);
	import mips_isa_pkg::*;
	import pipe_ctrl_pkg::*;

	opcode_t opcode;
	funct_t  funct;
	logic    is_add, is_sub, is_ori, is_lui, is_lw, is_sw, is_beq, is_jal, is_jr;
	// any class that produces a register result
	logic    writes_reg;

	// raw fields
	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign imm16  = instr[15:0];
	assign imm26  = instr[25:0];

	//////////////////////////////////////////////////
	// instruction class
	//////////////////////////////////////////////////

	assign is_add = (opcode == op_special) && (funct == fn_add);
	assign is_sub = (opcode == op_special) && (funct == fn_sub);
	assign is_jr  = (opcode == op_special) && (funct == fn_jr);
	assign is_ori = (opcode == op_ori);
	assign is_lui = (opcode == op_lui);
	assign is_lw  = (opcode == op_lw);
	assign is_sw  = (opcode == op_sw);
	assign is_beq = (opcode == op_beq);
	assign is_jal = (opcode == op_jal);
	// anything else falls through every select as a no-op

	//////////////////////////////////////////////////
	// selects
	//////////////////////////////////////////////////

	assign jump_sel = is_beq ? branch_imm16 :
		is_jal ? jump_imm26 :
		is_jr  ? jump_reg : pc_plus4;

	// loads and stores add the offset
	assign alu_op = is_sub ? alu_sub :
		is_ori ? alu_or :
		is_lui ? alu_lui : alu_add;

	// lui only keeps the low half, so sign or zero makes no difference
	assign src_b = (is_lui || is_lw || is_sw) ? src_sign_ext :
		is_ori ? src_zero_ext : src_rt;

	assign wdata_sel = is_lw ? wd_mem :
		is_jal ? wd_link : wd_alu;

	//////////////////////////////////////////////////
	// tuse / tnew
	//////////////////////////////////////////////////

	// branch and jr compare in decode
	assign tuse_rs = (is_add || is_sub || is_ori || is_lw || is_sw) ? 2'd1 :
		(is_beq || is_jr) ? 2'd0 : tuse_never;
	// store data not needed before memory stage
	assign tuse_rt = (is_add || is_sub) ? 2'd1 :
		is_sw  ? 2'd2 :
		is_beq ? 2'd0 : tuse_never;

	// link value exists already in execute
	assign tnew_e = (is_add || is_sub || is_ori || is_lui) ? 2'd1 :
		is_lw ? 2'd2 : 2'd0;
	assign tnew_m = is_lw ? 2'd1 : 2'd0;

	//////////////////////////////////////////////////
	// destination and enables
	//////////////////////////////////////////////////

	assign dest_reg = (is_add || is_sub) ? rd :
		(is_ori || is_lui || is_lw) ? rt :
		is_jal ? link_reg : 5'd0;

	assign writes_reg = is_add || is_sub || is_ori || is_lui || is_lw || is_jal;
	// r0 results are dropped here, so no stage ever sees them
	assign reg_we  = writes_reg && (dest_reg != 5'd0);
	assign mem_we  = is_sw;
	assign is_load = is_lw;

endmodule

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
	input  mips_isa_pkg::reg_addr_t    d_rs,
	input  mips_isa_pkg::reg_addr_t    d_rt,
	input  pipe_ctrl_pkg::stage_time_t d_tuse_rs,
	input  pipe_ctrl_pkg::stage_time_t d_tuse_rt,
	input  mips_isa_pkg::reg_addr_t    e_dest,
	input  pipe_ctrl_pkg::stage_time_t e_tnew,
	input  logic                       e_we,
	input  mips_isa_pkg::reg_addr_t    m_dest,
	input  pipe_ctrl_pkg::stage_time_t m_tnew,
	input  logic                       m_we,
	input  mips_isa_pkg::reg_addr_t    w_dest,
	input  logic                       w_we,
	output logic                       stall,
	output pipe_ctrl_pkg::fwd_sel_e    fwd_d_rs,
	output pipe_ctrl_pkg::fwd_sel_e    fwd_d_rt,
	output pipe_ctrl_pkg::fwd_sel_e    fwd_e_rs,
	output pipe_ctrl_pkg::fwd_sel_e    fwd_e_rt
);
	import mips_isa_pkg::*;
	import pipe_ctrl_pkg::*;

	logic e_rs_hit, e_rt_hit, m_rs_hit, m_rt_hit, w_rs_hit, w_rt_hit;

	// decode bypass picks the youngest producer
	// an unready producer leaves the register file value in place
	function automatic fwd_sel_e pick_d(input logic e_hit, input logic m_hit,
		input logic w_hit, input stage_time_t e_t, input stage_time_t m_t);
		if (e_hit)
			return (e_t == 2'd0) ? fwd_from_e : fwd_none;
		if (m_hit)
			return (m_t == 2'd0) ? fwd_from_m : fwd_none;
		return w_hit ? fwd_from_w : fwd_none;
	endfunction

	// r0 never matches
	assign e_rs_hit = e_we && (d_rs != 5'd0) && (d_rs == e_dest);
	assign e_rt_hit = e_we && (d_rt != 5'd0) && (d_rt == e_dest);
	assign m_rs_hit = m_we && (d_rs != 5'd0) && (d_rs == m_dest);
	assign m_rt_hit = m_we && (d_rt != 5'd0) && (d_rt == m_dest);
	assign w_rs_hit = w_we && (d_rs != 5'd0) && (d_rs == w_dest);
	assign w_rt_hit = w_we && (d_rt != 5'd0) && (d_rt == w_dest);

	// result arrives later than the operand is needed
	assign stall = (e_rs_hit && (e_tnew > d_tuse_rs)) || (e_rt_hit && (e_tnew > d_tuse_rt)) ||
		(m_rs_hit && (m_tnew > d_tuse_rs)) || (m_rt_hit && (m_tnew > d_tuse_rt));

	assign fwd_d_rs = pick_d(e_rs_hit, m_rs_hit, w_rs_hit, e_tnew, m_tnew);
	assign fwd_d_rt = pick_d(e_rt_hit, m_rt_hit, w_rt_hit, e_tnew, m_tnew);

	// execute selects for the next cycle
	// today's execute producer sits in memory then and today's memory one in write-back
	assign fwd_e_rs = e_rs_hit ? fwd_from_m : (m_rs_hit ? fwd_from_w : fwd_none);
	assign fwd_e_rt = e_rt_hit ? fwd_from_m : (m_rt_hit ? fwd_from_w : fwd_none);

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
	input  logic                    clk,
	input  logic                    reset,
	input  mips_isa_pkg::reg_addr_t ra1,
	input  mips_isa_pkg::reg_addr_t ra2,
	output mips_isa_pkg::word_t     rd1,
	output mips_isa_pkg::word_t     rd2,
	input  mips_isa_pkg::reg_addr_t wa,
	input  mips_isa_pkg::word_t     wd,
	input  logic                    we
);
	import mips_isa_pkg::*;

	word_t regs [32];
	// write lands this cycle, r0 excluded
	logic  wr_live;

	assign wr_live = we && (wa != 5'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wa] <= wd;
		end
	end

	// same-cycle write shows on the read ports
	assign rd1 = (wr_live && (wa == ra1)) ? wd : regs[ra1];
	assign rd2 = (wr_live && (wa == ra2)) ? wd : regs[ra2];

endmodule

// ==== rtl/instr_mem.sv ====
`timescale 1ns/1ns

module instr_mem #(
	parameter int imem_addr_bits = 8
) (
	input  logic                      clk,
	input  logic                      load_we,
	input  logic [imem_addr_bits-1:0] load_addr,
	input  mips_isa_pkg::instr_t      load_data,
	input  logic [imem_addr_bits+1:0] fetch_pc,
	output mips_isa_pkg::instr_t      fetch_instr
);
	import mips_isa_pkg::*;

	// one instruction per word
	instr_t mem [2**imem_addr_bits];

	// program load while the core is idle
	always_ff @(posedge clk) begin
		if (load_we) begin
			mem[load_addr] <= load_data;
		end
	end

	// byte pc, word lookup
	assign fetch_instr = mem[fetch_pc[imem_addr_bits+1:2]];

endmodule

// ==== rtl/data_mem.sv ====
`timescale 1ns/1ns

module data_mem #(
	parameter int dmem_addr_bits = 8
) (
	input  logic            clk,
	input  logic            reset,
	mem_bus_if.slave        bus
);
	import mips_isa_pkg::*;

	word_t ram [2**dmem_addr_bits];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**dmem_addr_bits; i++) begin
				ram[i] <= '0;
			end
		end else if (bus.we) begin
			ram[bus.word_idx] <= bus.wdata;
		end
	end

	// no wait states
	assign bus.rdata = ram[bus.word_idx];

endmodule

// ==== rtl/mips_pipeline.sv ====
`timescale 1ns/1ns

module mips_pipeline #(
	parameter int imem_addr_bits = 8,
	parameter int dmem_addr_bits = 8
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      run,
	output logic [imem_addr_bits+1:0] fetch_pc,
	input  mips_isa_pkg::instr_t      fetch_instr,
	mem_bus_if.master                 dbus,
	output logic                      wb_we,
	output mips_isa_pkg::reg_addr_t   wb_reg,
	output mips_isa_pkg::word_t       wb_data
);
	import mips_isa_pkg::*;
	import pipe_ctrl_pkg::*;

	// fetch
	word_t pc, pc_next;
	// fetch / decode
	logic fd_valid;
	instr_t fd_instr, d_instr;
	word_t fd_pc, d_pc4;
	// decoder outputs
	reg_addr_t d_rs, d_rt, d_dest;
	logic [15:0] d_imm16;
	logic [25:0] d_imm26;
	jump_sel_e d_jump_sel;
	alu_op_e d_alu_op;
	src_b_e d_src_b;
	wdata_sel_e d_wdata_sel;
	stage_time_t d_tuse_rs, d_tuse_rt, d_tnew_e, d_tnew_m;
	logic d_reg_we, d_mem_we, d_is_load;
	// hazard
	logic stall;
	fwd_sel_e fwd_d_rs, fwd_d_rt, fwd_e_rs, fwd_e_rt;
	word_t rf_rd1, rf_rd2, d_rs_val, d_rt_val;
	// decode / execute
	logic de_valid, de_reg_we, de_mem_we, de_is_load;
	word_t de_rs_val, de_rt_val, de_link;
	logic [15:0] de_imm16;
	alu_op_e de_alu_op;
	src_b_e de_src_b;
	wdata_sel_e de_wdata_sel;
	stage_time_t de_tnew_e, de_tnew_m;
	reg_addr_t de_dest, de_rt;
	fwd_sel_e de_fwd_rs, de_fwd_rt;
	word_t e_a, e_rt_val, e_b, e_alu;
	// execute / memory
	logic em_valid, em_reg_we, em_mem_we, em_is_load;
	word_t em_alu, em_store, em_link, m_result, m_store;
	wdata_sel_e em_wdata_sel;
	stage_time_t em_tnew_m;
	reg_addr_t em_dest, em_rt;
	// memory / write-back
	logic mw_valid, mw_reg_we, mw_is_load;
	reg_addr_t mw_dest;
	word_t mw_data;

	//////////////////////////////////////////////////
	// valid bits and pc
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			fd_valid <= 1'b0;
			de_valid <= 1'b0;
			em_valid <= 1'b0;
			mw_valid <= 1'b0;
		end else begin
			// stall freezes fetch and decode
			if (!stall) begin
				fd_valid <= run;
				if (run) begin
					pc <= pc_next;
				end
			end
			// bubble into execute on stall
			de_valid <= fd_valid && !stall;
			em_valid <= de_valid;
			mw_valid <= em_valid;
		end
	end

	assign fetch_pc = pc[imem_addr_bits+1:0];

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////

	// empty slot decodes as a no-op
	assign d_instr = fd_valid ? fd_instr : '0;
	assign d_pc4 = fd_pc + 32'd4;

	insn_decoder u_dec (
		.instr(d_instr), .rs(d_rs), .rt(d_rt), .rd(), .imm16(d_imm16), .imm26(d_imm26),
		.jump_sel(d_jump_sel), .alu_op(d_alu_op), .src_b(d_src_b), .wdata_sel(d_wdata_sel),
		.tuse_rs(d_tuse_rs), .tuse_rt(d_tuse_rt), .tnew_e(d_tnew_e), .tnew_m(d_tnew_m),
		.dest_reg(d_dest), .reg_we(d_reg_we), .mem_we(d_mem_we), .is_load(d_is_load)
	);

	hazard_unit u_hz (
		.d_rs(d_rs), .d_rt(d_rt), .d_tuse_rs(d_tuse_rs), .d_tuse_rt(d_tuse_rt),
		.e_dest(de_dest), .e_tnew(de_tnew_e), .e_we(de_valid && de_reg_we),
		.m_dest(em_dest), .m_tnew(em_tnew_m), .m_we(em_valid && em_reg_we),
		.w_dest(mw_dest), .w_we(wb_we), .stall(stall),
		.fwd_d_rs(fwd_d_rs), .fwd_d_rt(fwd_d_rt), .fwd_e_rs(fwd_e_rs), .fwd_e_rt(fwd_e_rt)
	);

	reg_file u_rf (
		.clk(clk), .reset(reset), .ra1(d_rs), .ra2(d_rt), .rd1(rf_rd1), .rd2(rf_rd2),
		.wa(mw_dest), .wd(mw_data), .we(wb_we)
	);

	// decode bypass, link from execute, result from memory
	always_comb begin
		case (fwd_d_rs)
			fwd_from_e: d_rs_val = de_link;
			fwd_from_m: d_rs_val = m_result;
			fwd_from_w: d_rs_val = mw_data;
			default:    d_rs_val = rf_rd1;
		endcase
		case (fwd_d_rt)
			fwd_from_e: d_rt_val = de_link;
			fwd_from_m: d_rt_val = m_result;
			fwd_from_w: d_rt_val = mw_data;
			default:    d_rt_val = rf_rd2;
		endcase
	end

	// redirect takes effect after the delay slot fetch
	always_comb begin
		pc_next = pc + 32'd4;
		case (d_jump_sel)
			branch_imm16: begin
				if (d_rs_val == d_rt_val) begin
					pc_next = d_pc4 + {{14{d_imm16[15]}}, d_imm16, 2'b00};
				end
			end
			jump_imm26: pc_next = {d_pc4[31:28], d_imm26, 2'b00};
			jump_reg:   pc_next = d_rs_val;
			default:    pc_next = pc + 32'd4;
		endcase
	end

	//////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////

	// selects chosen one cycle earlier in decode
	always_comb begin
		case (de_fwd_rs)
			fwd_from_m: e_a = m_result;
			fwd_from_w: e_a = mw_data;
			default:    e_a = de_rs_val;
		endcase
		case (de_fwd_rt)
			fwd_from_m: e_rt_val = m_result;
			fwd_from_w: e_rt_val = mw_data;
			default:    e_rt_val = de_rt_val;
		endcase
		case (de_src_b)
			src_sign_ext: e_b = {{16{de_imm16[15]}}, de_imm16};
			src_zero_ext: e_b = {16'h0000, de_imm16};
			default:      e_b = e_rt_val;
		endcase
		case (de_alu_op)
			alu_sub: e_alu = e_a - e_b;
			alu_or:  e_alu = e_a | e_b;
			alu_lui: e_alu = {e_b[15:0], 16'h0000};
			default: e_alu = e_a + e_b;
		endcase
	end

	//////////////////////////////////////////////////
	// memory and write-back
	//////////////////////////////////////////////////

	// value ready in memory stage for bypass
	assign m_result = (em_wdata_sel == wd_link) ? em_link : em_alu;
	// lw directly ahead of sw, load data arrives only now
	assign m_store = (mw_valid && mw_reg_we && mw_is_load && (mw_dest == em_rt)) ?
		mw_data : em_store;

	// address folded into the RAM range
	assign dbus.addr  = word_t'(em_alu[dmem_addr_bits+1:0]);
	assign dbus.wdata = m_store;
	assign dbus.we    = em_valid && em_mem_we;

	assign wb_we   = mw_valid && mw_reg_we;
	assign wb_reg  = mw_dest;
	assign wb_data = mw_data;

	// payload registers, qualified by the valid bits
	always_ff @(posedge clk) begin
		if (!stall) begin
			fd_instr <= fetch_instr;
			fd_pc <= pc;
		end
		de_rs_val <= d_rs_val;
		de_rt_val <= d_rt_val;
		// jal return skips the delay slot
		de_link <= fd_pc + 32'd8;
		de_imm16 <= d_imm16;
		de_alu_op <= d_alu_op;
		de_src_b <= d_src_b;
		de_wdata_sel <= d_wdata_sel;
		de_tnew_e <= d_tnew_e;
		de_tnew_m <= d_tnew_m;
		de_dest <= d_dest;
		de_rt <= d_rt;
		de_reg_we <= d_reg_we;
		de_mem_we <= d_mem_we;
		de_is_load <= d_is_load;
		de_fwd_rs <= fwd_e_rs;
		de_fwd_rt <= fwd_e_rt;
		em_alu <= e_alu;
		em_store <= e_rt_val;
		em_link <= de_link;
		em_wdata_sel <= de_wdata_sel;
		em_tnew_m <= de_tnew_m;
		em_dest <= de_dest;
		em_rt <= de_rt;
		em_reg_we <= de_reg_we;
		em_mem_we <= de_mem_we;
		em_is_load <= de_is_load;
		// write-back value picked on entry to the last stage
		mw_data <= (em_wdata_sel == wd_mem) ? dbus.rdata : m_result;
		mw_dest <= em_dest;
		mw_reg_we <= em_reg_we;
		mw_is_load <= em_is_load;
	end

endmodule

// ==== rtl/mips_core_top.sv ====
`timescale 1ns/1ns

module mips_core_top #(
	parameter int imem_addr_bits = 8,
	parameter int dmem_addr_bits = 8
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      run,
	input  logic                      load_we,
	input  logic [imem_addr_bits-1:0] load_addr,
	input  mips_isa_pkg::instr_t      load_data,
	output logic                      wb_we,
	output mips_isa_pkg::reg_addr_t   wb_reg,
	output mips_isa_pkg::word_t       wb_data,
	output logic                      st_we,
	output mips_isa_pkg::word_t       st_addr,
	output mips_isa_pkg::word_t       st_data
);
	import mips_isa_pkg::*;

	// fetch path
	logic [imem_addr_bits+1:0] fetch_pc;
	instr_t fetch_instr;

	// data memory port
	mem_bus_if #(.dmem_addr_bits(dmem_addr_bits)) dbus ();

	mips_pipeline #(
		.imem_addr_bits(imem_addr_bits),
		.dmem_addr_bits(dmem_addr_bits)
	) u_pipe (
		.clk(clk), .reset(reset), .run(run),
		.fetch_pc(fetch_pc), .fetch_instr(fetch_instr), .dbus(dbus.master),
		.wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	instr_mem #(.imem_addr_bits(imem_addr_bits)) u_imem (
		.clk(clk), .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
		.fetch_pc(fetch_pc), .fetch_instr(fetch_instr)
	);

	data_mem #(.dmem_addr_bits(dmem_addr_bits)) u_dmem (
		.clk(clk), .reset(reset), .bus(dbus.slave)
	);

	// store requests seen at the memory port
	assign st_we   = dbus.we;
	assign st_addr = dbus.addr;
	assign st_data = dbus.wdata;

endmodule

// ==== dv/tb_mips_core.sv ====
`timescale 1ns/1ns

module tb_mips_core;

	localparam int imem_bits = 8;
	localparam int dmem_bits = 8;
	// six tests of at most 200 cycles, plus margin
	localparam int max_cycles = 1500;
	// wait for write-backs inside one test
	localparam int test_limit = 150;
	// quiet cycles after the last write-back
	localparam int settle_cycles = 12;

	logic                 clk;
	logic                 reset;
	logic                 run;
	logic                 load_we;
	logic [imem_bits-1:0] load_addr;
	logic [31:0]          load_data;
	logic                 wb_we;
	logic [4:0]           wb_reg;
	logic [31:0]          wb_data;
	logic                 st_we;
	logic [31:0]          st_addr;
	logic [31:0]          st_data;

	int          errors = 0;
	int          cycle_count = 0;
	string       cur_test;
	logic [31:0] rng_state;

	// program image for the current test
	logic [31:0] prog[$];
	// traffic seen at the top level
	logic [4:0]  seen_reg[$];
	logic [31:0] seen_data[$];
	logic [31:0] seen_st_addr[$];
	logic [31:0] seen_st_data[$];
	// predicted traffic
	logic [4:0]  exp_reg[$];
	logic [31:0] exp_data[$];
	logic [31:0] exp_st_addr[$];
	logic [31:0] exp_st_data[$];

	mips_core_top #(.imem_addr_bits(imem_bits), .dmem_addr_bits(dmem_bits)) dut (
		.clk(clk), .reset(reset), .run(run), .load_we(load_we), .load_addr(load_addr),
		.load_data(load_data), .wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data),
		.st_we(st_we), .st_addr(st_addr), .st_data(st_data)
	);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// global watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// sampled mid-cycle, outputs settled by then
	always @(negedge clk) begin
		if (wb_we === 1'b1) begin
			seen_reg.push_back(wb_reg);
			seen_data.push_back(wb_data);
		end
		if (st_we === 1'b1) begin
			seen_st_addr.push_back(st_addr);
			seen_st_data.push_back(st_data);
		end
	end

	//////////////////////////////////////////////////
	// instruction encoding
	//////////////////////////////////////////////////

	function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] add_instr(input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt);
		return r_type(rs, rt, rd, 6'h20);
	endfunction

	function automatic logic [31:0] sub_instr(input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt);
		return r_type(rs, rt, rd, 6'h22);
	endfunction

	function automatic logic [31:0] jr_instr(input logic [4:0] rs);
		return r_type(rs, 5'd0, 5'd0, 6'h08);
	endfunction

	function automatic logic [31:0] ori_instr(input logic [4:0] rt, input logic [4:0] rs,
		input logic [15:0] imm);
		return i_type(6'h0d, rs, rt, imm);
	endfunction

	function automatic logic [31:0] lui_instr(input logic [4:0] rt, input logic [15:0] imm);
		return i_type(6'h0f, 5'd0, rt, imm);
	endfunction

	function automatic logic [31:0] lw_instr(input logic [4:0] rt, input logic [15:0] off,
		input logic [4:0] base);
		return i_type(6'h23, base, rt, off);
	endfunction

	function automatic logic [31:0] sw_instr(input logic [4:0] rt, input logic [15:0] off,
		input logic [4:0] base);
		return i_type(6'h2b, base, rt, off);
	endfunction

	// offset in words from the delay slot
	function automatic logic [31:0] beq_instr(input logic [4:0] rs, input logic [4:0] rt,
		input logic [15:0] off);
		return i_type(6'h04, rs, rt, off);
	endfunction

	// target is a byte address in the same 256 MB region
	function automatic logic [31:0] jal_instr(input logic [31:0] target);
		return {6'h03, target[27:2]};
	endfunction

	// xorshift32
	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	//////////////////////////////////////////////////
	// test flow
	//////////////////////////////////////////////////

	// next edge, then the drive offset
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic expect_wb(input logic [4:0] r, input logic [31:0] d);
		exp_reg.push_back(r);
		exp_data.push_back(d);
	endtask

	task automatic expect_st(input logic [31:0] a, input logic [31:0] d);
		exp_st_addr.push_back(a);
		exp_st_data.push_back(d);
	endtask

	// core idle and cleared, all queues empty
	task automatic start_test(input string name);
		cur_test = name;
		run = 1'b0;
		load_we = 1'b0;
		reset = 1'b1;
		repeat (2) tick();
		reset = 1'b0;
		prog.delete();
		seen_reg.delete();
		seen_data.delete();
		seen_st_addr.delete();
		seen_st_data.delete();
		exp_reg.delete();
		exp_data.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
	endtask

	task automatic check_results();
		int n;
		if (seen_reg.size() != exp_reg.size()) begin
			$display("%s: expected %0d write-backs but saw %0d", cur_test, exp_reg.size(),
				seen_reg.size());
			errors++;
		end
		n = (seen_reg.size() < exp_reg.size()) ? seen_reg.size() : exp_reg.size();
		for (int i = 0; i < n; i++) begin
			if (seen_reg[i] !== exp_reg[i]) begin
				$display("ERR %s wb %0d reg: expected %0d actual %0d", cur_test, i,
					exp_reg[i], seen_reg[i]);
				errors++;
			end
			if (seen_data[i] !== exp_data[i]) begin
				$display("ERR %s wb %0d data: expected %08h actual %08h", cur_test, i,
					exp_data[i], seen_data[i]);
				errors++;
			end
		end
		if (seen_st_addr.size() != exp_st_addr.size()) begin
			$display("%s: expected %0d stores but saw %0d", cur_test, exp_st_addr.size(),
				seen_st_addr.size());
			errors++;
		end
		n = (seen_st_addr.size() < exp_st_addr.size()) ? seen_st_addr.size() :
			exp_st_addr.size();
		for (int i = 0; i < n; i++) begin
			if (seen_st_addr[i] !== exp_st_addr[i]) begin
				$display("ERR %s store %0d addr: expected %08h actual %08h", cur_test, i,
					exp_st_addr[i], seen_st_addr[i]);
				errors++;
			end
			if (seen_st_data[i] !== exp_st_data[i]) begin
				$display("ERR %s store %0d data: expected %08h actual %08h", cur_test, i,
					exp_st_data[i], seen_st_data[i]);
				errors++;
			end
		end
	endtask

	// load, start, wait for the predicted write-backs, then compare
	task automatic run_program();
		int waited;
		// halt loop, beq r0 to itself with a no-op delay slot
		prog.push_back(beq_instr(5'd0, 5'd0, 16'hffff));
		prog.push_back(32'h0000_0000);
		foreach (prog[i]) begin
			load_we = 1'b1;
			load_addr = imem_bits'(i);
			load_data = prog[i];
			tick();
		end
		load_we = 1'b0;
		run = 1'b1;
		waited = 0;
		while ((seen_reg.size() < exp_reg.size()) && (waited < test_limit)) begin
			tick();
			waited++;
		end
		if (seen_reg.size() < exp_reg.size()) begin
			$display("%s: only %0d of %0d write-backs arrived within %0d cycles", cur_test,
				seen_reg.size(), exp_reg.size(), test_limit);
			errors++;
		end
		// anything arriving now is a stray write-back
		repeat (settle_cycles) tick();
		run = 1'b0;
		check_results();
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	// back to back dependencies, operands from E, M and W
	task automatic alu_chain();
		logic [31:0] r1, r2, r3, r4, r5, r6, r7;
		start_test("alu_chain");
		r1 = 32'h1234_0000;
		r2 = r1 | 32'h0000_5678;
		r3 = r2 + r1;
		r4 = r3 - r2;
		r5 = r4 + r3;
		r6 = r1 - r5;
		r7 = r4 + r6;
		prog.push_back(lui_instr(5'd1, 16'h1234));
		prog.push_back(ori_instr(5'd2, 5'd1, 16'h5678));
		prog.push_back(add_instr(5'd3, 5'd2, 5'd1));
		prog.push_back(sub_instr(5'd4, 5'd3, 5'd2));
		prog.push_back(add_instr(5'd5, 5'd4, 5'd3));
		prog.push_back(sub_instr(5'd6, 5'd1, 5'd5));
		// r4 three back, comes from write-back
		prog.push_back(add_instr(5'd7, 5'd4, 5'd6));
		expect_wb(5'd1, r1);
		expect_wb(5'd2, r2);
		expect_wb(5'd3, r3);
		expect_wb(5'd4, r4);
		expect_wb(5'd5, r5);
		expect_wb(5'd6, r6);
		expect_wb(5'd7, r7);
		run_program();
	endtask

	// stores, loads and immediate use of loaded data
	task automatic load_use();
		logic [31:0] base, w0, w1, sum;
		start_test("load_use");
		base = 32'h10;
		w0 = 32'h0abc;
		w1 = 32'hdead_0000;
		sum = w1 + w0;
		prog.push_back(ori_instr(5'd1, 5'd0, 16'h0010));
		prog.push_back(ori_instr(5'd2, 5'd0, 16'h0abc));
		prog.push_back(lui_instr(5'd3, 16'hdead));
		prog.push_back(sw_instr(5'd2, 16'd0, 5'd1));
		prog.push_back(sw_instr(5'd3, 16'd4, 5'd1));
		prog.push_back(lw_instr(5'd4, 16'd0, 5'd1));
		prog.push_back(add_instr(5'd5, 5'd4, 5'd4));
		prog.push_back(lw_instr(5'd6, 16'd4, 5'd1));
		prog.push_back(add_instr(5'd7, 5'd6, 5'd2));
		prog.push_back(sw_instr(5'd7, 16'd8, 5'd1));
		// load result stored by the very next instruction
		prog.push_back(lw_instr(5'd8, 16'd8, 5'd1));
		prog.push_back(sw_instr(5'd8, 16'd12, 5'd1));
		expect_wb(5'd1, base);
		expect_wb(5'd2, w0);
		expect_wb(5'd3, w1);
		expect_wb(5'd4, w0);
		expect_wb(5'd5, w0 + w0);
		expect_wb(5'd6, w1);
		expect_wb(5'd7, sum);
		expect_wb(5'd8, sum);
		expect_st(base, w0);
		expect_st(base + 32'd4, w1);
		expect_st(base + 32'd8, sum);
		expect_st(base + 32'd12, sum);
		run_program();
	endtask

	// taken and not taken, delay slot always runs
	task automatic branch_delay();
		start_test("branch_delay");
		prog.push_back(ori_instr(5'd1, 5'd0, 16'd5));
		prog.push_back(ori_instr(5'd2, 5'd0, 16'd5));
		// 8, taken to 20
		prog.push_back(beq_instr(5'd1, 5'd2, 16'd2));
		prog.push_back(ori_instr(5'd3, 5'd0, 16'h11));
		// skipped
		prog.push_back(ori_instr(5'd4, 5'd0, 16'h22));
		prog.push_back(ori_instr(5'd5, 5'd0, 16'h33));
		// 24, 5 vs 0x11 falls through
		prog.push_back(beq_instr(5'd1, 5'd3, 16'd2));
		prog.push_back(ori_instr(5'd6, 5'd0, 16'h44));
		prog.push_back(ori_instr(5'd7, 5'd0, 16'h55));
		prog.push_back(ori_instr(5'd8, 5'd0, 16'h66));
		expect_wb(5'd1, 32'd5);
		expect_wb(5'd2, 32'd5);
		expect_wb(5'd3, 32'h11);
		expect_wb(5'd5, 32'h33);
		expect_wb(5'd6, 32'h44);
		expect_wb(5'd7, 32'h55);
		expect_wb(5'd8, 32'h66);
		run_program();
	endtask

	// call at 4 into 24, return to 12
	task automatic jal_jr();
		logic [31:0] jal_pc;
		start_test("jal_jr");
		jal_pc = 32'd4;
		prog.push_back(ori_instr(5'd1, 5'd0, 16'h7));
		prog.push_back(jal_instr(32'd24));
		prog.push_back(ori_instr(5'd2, 5'd0, 16'h8));
		// return point
		prog.push_back(ori_instr(5'd3, 5'd0, 16'h9));
		prog.push_back(beq_instr(5'd0, 5'd0, 16'hffff));
		prog.push_back(32'h0000_0000);
		// callee
		prog.push_back(ori_instr(5'd4, 5'd0, 16'hbeef));
		prog.push_back(jr_instr(5'd31));
		prog.push_back(ori_instr(5'd5, 5'd0, 16'h5));
		// never reached
		prog.push_back(ori_instr(5'd6, 5'd0, 16'h66));
		expect_wb(5'd1, 32'h7);
		expect_wb(5'd31, jal_pc + 32'd8);
		expect_wb(5'd2, 32'h8);
		expect_wb(5'd4, 32'hbeef);
		expect_wb(5'd5, 32'h5);
		expect_wb(5'd3, 32'h9);
		run_program();
	endtask

	// r0 targets are silent, r0 reads as zero
	task automatic zero_reg();
		start_test("zero_reg");
		prog.push_back(ori_instr(5'd1, 5'd0, 16'h40));
		prog.push_back(ori_instr(5'd0, 5'd1, 16'h123));
		prog.push_back(add_instr(5'd0, 5'd1, 5'd1));
		prog.push_back(add_instr(5'd2, 5'd0, 5'd1));
		prog.push_back(lui_instr(5'd0, 16'h55));
		prog.push_back(ori_instr(5'd3, 5'd0, 16'h1));
		prog.push_back(lw_instr(5'd0, 16'd0, 5'd1));
		prog.push_back(sub_instr(5'd4, 5'd1, 5'd0));
		expect_wb(5'd1, 32'h40);
		expect_wb(5'd2, 32'h40);
		expect_wb(5'd3, 32'h1);
		expect_wb(5'd4, 32'h40);
		run_program();
	endtask

	// ori into r1..r6, add into r7..r11, tracked by a register model
	task automatic random_ori_add();
		logic [31:0] model [32];
		logic [31:0] rnd;
		logic [15:0] imm;
		logic [4:0]  d1, d2, prev;
		start_test("random_ori_add");
		foreach (model[r]) begin
			model[r] = 32'h0;
		end
		prev = 5'd0;
		for (int i = 0; i < 20; i++) begin
			rnd = xorshift32();
			imm = rnd[15:0];
			d1 = 5'(1 + (i % 6));
			d2 = 5'(7 + (i % 5));
			prog.push_back(ori_instr(d1, prev, imm));
			model[d1] = model[prev] | {16'h0000, imm};
			expect_wb(d1, model[d1]);
			prog.push_back(add_instr(d2, d1, prev));
			model[d2] = model[d1] + model[prev];
			expect_wb(d2, model[d2]);
			prev = d2;
		end
		run_program();
	endtask

	initial begin
		reset = 1'b1;
		run = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		rng_state = 32'he92262db;
		alu_chain();
		load_use();
		branch_delay();
		jal_jr();
		zero_reg();
		random_ori_add();
		$display("tb_mips_core: 6 tests run, %0d errors", errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
rtl/mips_isa_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/mem_bus_if.sv
rtl/insn_decoder.sv
rtl/hazard_unit.sv
rtl/reg_file.sv
rtl/instr_mem.sv
rtl/data_mem.sv
rtl/mips_pipeline.sv
rtl/mips_core_top.sv
dv/tb_mips_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 -Wno-fatal --top-module tb_mips_core -f filelist.f -o tb_mips_core
./obj_dir/tb_mips_core > sim.log 2>&1
cat sim.log
if grep -qF '*** TEST PASSED ***' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
